// File: Makefile
LOG = sim.log

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f tb.f --top-module tbPermAccel -o simv
	./obj_dir/simv > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: help test clean

// File: permPipe_params.svh
`ifndef PERM_PIPE_PARAMS_SVH
`define PERM_PIPE_PARAMS_SVH

// Origin queue holds 32 tags
`define PERM_ORIGIN_DEPTH_LOG2 5

// Result buffer holds 8 words
`define PERM_RESULT_DEPTH_LOG2 3

`define PERM_PIPE_LATENCY 3

// Room for every bot still in the pipeline plus the one being accepted
`define PERM_RESULT_MARGIN (`PERM_PIPE_LATENCY + 1)

`define PERM_RESET_CYCLES 4

`endif

// File: permPkg.sv
package permPkg;

    // One 128-entry truth table, used for both top and bot
    typedef logic [127:0] bitset_t;

    // Output word, shared by bot results and profiling words
    typedef struct packed {
        logic [2:0]  reserved;  // Always zero
        logic [12:0] count;     // Number of qualifying permutations
        logic [47:0] sum;       // Sum of missing top bits over those permutations
    } result_t;

    // Where a queued result comes from
    typedef enum logic {
        ORIGIN_TOP = 1'b0,  // Profiling word
        ORIGIN_BOT = 1'b1   // Compute pipeline result
    } origin_t;

    // Number of rotated views checked per bot
    localparam int NUM_PERMS = 4;
    localparam int PERM_STEP = 32;  // Rotation step in bits

endpackage

// File: permutationAccelerator.sv
`timescale 1ns/1ns

module permutationAccelerator (
    input  logic             clk,
    input  logic             resetn,
    input  logic             ivalid,
    input  logic             startNewTop,
    input  logic             iready,
    input  logic [63:0]      botLower,
    input  logic [63:0]      botUpper,
    output logic             oready,
    output logic             ovalid,
    output permPkg::result_t resultOut
);

    import permPkg::*;

    bitset_t storedWord;
    logic    botValid;
    logic    topValid;
    logic    rst;
    logic    initDone;
    logic    collectorReady;

    // One-deep input register, refilled whenever the kernel can take a word
    always_ff @(posedge clk) begin
        if (!resetn) begin
            botValid <= 1'b0;
            topValid <= 1'b0;
        end else if (oready) begin
            botValid <= ivalid && !startNewTop;
            topValid <= ivalid && startNewTop;
        end
    end

    always_ff @(posedge clk) begin
        if (oready) storedWord <= {botUpper, botLower};
    end

    resetNormalizer rstNorm (
        .clk     (clk),
        .resetn  (resetn),
        .rst     (rst),
        .initDone(initDone)
    );

    // Empty register can always accept, even before the queues are up
    assign oready = (collectorReady && initDone) || (!botValid && !topValid && !rst);

    resultCollector collector (
        .clk          (clk),
        .rst          (rst),
        .writeBot     (botValid && oready),
        .writeTop     (topValid && oready),
        .iready       (iready),
        .word         (storedWord),
        .readyForInput(collectorReady),
        .ovalid       (ovalid),
        .resultOut    (resultOut)
    );

endmodule

// File: permutationPipeline.sv
`timescale 1ns/1ns
`include "permPipe_params.svh"

module permutationPipeline (
    input  logic             clk,
    input  logic             rst,
    input  logic             writeBot,
    input  logic             grabResult,
    input  permPkg::bitset_t top,
    input  permPkg::bitset_t bot,
    output logic             readyForInput,
    output logic             resultValid,
    output permPkg::result_t resultOut,
    output logic [1:0]       activity
);

    import permPkg::*;

    function automatic bitset_t rotateLeft(input bitset_t value, input int lane);
        int shift;
        shift = lane * PERM_STEP;
        return (value << shift) | (value >> (128 - shift));
    endfunction

    function automatic logic [7:0] popCount(input bitset_t value);
        logic [7:0] total;
        total = '0;
        for (int i = 0; i < 128; i++) begin
            total = total + 8'(value[i]);
        end
        return total;
    endfunction

    logic                   s1Valid, s2Valid, s3Valid;
    bitset_t                s1Rot [NUM_PERMS];
    logic [NUM_PERMS-1:0]   s1Subset;
    logic [7:0]             s2Missing [NUM_PERMS];
    logic [2:0]             s2Count;
    result_t                s3Result;
    logic                   bufferAlmostFull;
    logic                   bufferEmpty;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
            s3Valid <= 1'b0;
        end else begin
            s1Valid <= writeBot;
            s2Valid <= s1Valid;
            s3Valid <= s2Valid;
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < NUM_PERMS; k++) begin
            if (writeBot) begin
                s1Rot[k]    <= rotateLeft(bot, k);
                s1Subset[k] <= ((rotateLeft(bot, k) & ~top) == '0);  // Every bot bit also in top
            end
            if (s1Valid) begin
                s2Missing[k] <= s1Subset[k] ? popCount(top & ~s1Rot[k]) : 8'd0;
            end
        end
        if (s1Valid) s2Count <= 3'($countones(s1Subset));
        if (s2Valid) begin
            s3Result.reserved <= '0;
            s3Result.count    <= 13'(s2Count);
            s3Result.sum      <= 48'(s2Missing[0]) + 48'(s2Missing[1])
                               + 48'(s2Missing[2]) + 48'(s2Missing[3]);
        end
    end

    syncFifo #(
        .dataType        (result_t),
        .depthLog2       (`PERM_RESULT_DEPTH_LOG2),
        .almostFullMargin(`PERM_RESULT_MARGIN)
    ) resultBuffer (
        .clk        (clk),
        .rst        (rst),
        .writeEnable(s3Valid),  // Lands 3 cycles after writeBot
        .dataIn     (s3Result),
        .almostFull (bufferAlmostFull),
        .readEnable (grabResult),
        .dataOut    (resultOut),
        .empty      (bufferEmpty)
    );

    assign readyForInput = !bufferAlmostFull;
    assign resultValid   = !bufferEmpty;
    assign activity      = {1'b0, s1Valid} + {1'b0, s2Valid} + {1'b0, s3Valid};

endmodule

// File: resetNormalizer.sv
`timescale 1ns/1ns
`include "permPipe_params.svh"

module resetNormalizer (
    input  logic clk,
    input  logic resetn,
    output logic rst,
    output logic initDone
);

    localparam int COUNT_WIDTH = $clog2(`PERM_RESET_CYCLES + 1);

    logic [COUNT_WIDTH-1:0] holdCount;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            holdCount <= COUNT_WIDTH'(`PERM_RESET_CYCLES);
            rst       <= 1'b1;
            initDone  <= 1'b0;
        end else begin
            if (holdCount != '0) begin
                holdCount <= holdCount - 1'b1;
            end
            rst      <= (holdCount != '0);  // Held until the counter runs out
            initDone <= !rst;               // One cycle behind the falling rst
        end
    end

endmodule

// File: resultCollector.sv
`timescale 1ns/1ns
`include "permPipe_params.svh"

module resultCollector (
    input  logic             clk,
    input  logic             rst,
    input  logic             writeBot,
    input  logic             writeTop,
    input  logic             iready,
    input  permPkg::bitset_t word,
    output logic             readyForInput,
    output logic             ovalid,
    output permPkg::result_t resultOut
);

    import permPkg::*;

    // Covers the word already sitting in the input register
    localparam int ORIGIN_MARGIN = 2;

    origin_t     headOrigin;
    logic        originEmpty;
    logic        originAlmostFull;
    logic        grabbing;
    logic        grabResult;
    logic        clearProfile;
    bitset_t     top;
    logic        stallInput;
    logic        pipeReady;
    logic        pipeValid;
    result_t     pipeResult;
    logic [1:0]  activity;
    logic [30:0] cycleCount;
    logic [29:0] activityCount;

    syncFifo #(
        .dataType        (origin_t),
        .depthLog2       (`PERM_ORIGIN_DEPTH_LOG2),
        .almostFullMargin(ORIGIN_MARGIN)
    ) originQueue (
        .clk        (clk),
        .rst        (rst),
        .writeEnable(writeTop || writeBot),
        .dataIn     (writeTop ? ORIGIN_TOP : ORIGIN_BOT),
        .almostFull (originAlmostFull),
        .readEnable (grabbing),
        .dataOut    (headOrigin),
        .empty      (originEmpty)
    );

    // Profiling words are always ready and bot words wait for the pipeline
    assign ovalid       = !originEmpty && (headOrigin == ORIGIN_TOP || pipeValid);
    assign grabbing     = ovalid && iready;
    assign grabResult   = grabbing && headOrigin == ORIGIN_BOT;
    assign clearProfile = grabbing && headOrigin == ORIGIN_TOP;

    always_ff @(posedge clk) begin
        if (rst) begin
            cycleCount    <= '0;
            activityCount <= '0;
        end else if (clearProfile) begin
            cycleCount    <= 31'd1;  // Read cycle opens the next period
            activityCount <= 30'(activity);
        end else begin
            cycleCount    <= cycleCount + 1'b1;
            activityCount <= activityCount + 30'(activity);
        end
    end

    assign resultOut = (headOrigin == ORIGIN_TOP) ? result_t'({3'b000, activityCount, cycleCount})
                                                  : pipeResult;

    assign readyForInput = pipeReady && !originAlmostFull && !stallInput;

    topManager topMngr (
        .clk       (clk),
        .rst       (rst),
        .topValid  (writeTop),
        .botWrite  (writeBot),
        .botDrained(grabResult),
        .topIn     (word),
        .topOut    (top),
        .stallInput(stallInput)
    );

    permutationPipeline permPipe (
        .clk          (clk),
        .rst          (rst),
        .writeBot     (writeBot),
        .grabResult   (grabResult),
        .top          (top),
        .bot          (word),
        .readyForInput(pipeReady),
        .resultValid  (pipeValid),
        .resultOut    (pipeResult),
        .activity     (activity)
    );

endmodule

// File: syncFifo.sv
`timescale 1ns/1ns

module syncFifo #(
    parameter type dataType         = logic [7:0],
    parameter int  depthLog2        = 4,
    parameter int  almostFullMargin = 1
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    writeEnable,
    input  dataType dataIn,
    output logic    almostFull,
    input  logic    readEnable,
    output dataType dataOut,
    output logic    empty
);

    localparam int DEPTH = 1 << depthLog2;

    dataType              storage [DEPTH];
    logic [depthLog2-1:0] writePtr;
    logic [depthLog2-1:0] readPtr;
    logic [depthLog2:0]   fillCount;
    logic [depthLog2:0]   freeSlots;
    logic                 doWrite;
    logic                 doRead;

    assign doWrite = writeEnable && (fillCount != (depthLog2 + 1)'(DEPTH));  // Drop writes when full
    assign doRead  = readEnable && (fillCount != '0);

    always_ff @(posedge clk) begin
        if (doWrite) begin
            storage[writePtr] <= dataIn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            writePtr  <= '0;
            readPtr   <= '0;
            fillCount <= '0;
        end else begin
            if (doWrite) writePtr <= writePtr + 1'b1;
            if (doRead) readPtr <= readPtr + 1'b1;
            fillCount <= fillCount + (depthLog2 + 1)'(doWrite) - (depthLog2 + 1)'(doRead);
        end
    end

    // Show-ahead head entry
    assign dataOut    = storage[readPtr];
    assign empty      = (fillCount == '0);
    assign freeSlots  = (depthLog2 + 1)'(DEPTH) - fillCount;
    assign almostFull = (freeSlots <= (depthLog2 + 1)'(almostFullMargin));

endmodule

// File: tb.f
+incdir+.
permPkg.sv
syncFifo.sv
resetNormalizer.sv
topManager.sv
permutationPipeline.sv
resultCollector.sv
permutationAccelerator.sv
tbPermAccel.sv

// File: tbPermAccel.sv
`timescale 1ns/1ns

module tbPermAccel;

    import permPkg::*;

    typedef struct {
        bit        valid;
        bit        newTop;
        bitset_t   word;
        bit [15:0] readyPattern;  // iready per cycle and held high after 16 cycles
    } stimEntry_t;

    typedef struct {
        bit      isTop;
        result_t word;
    } expected_t;

    logic        clk;
    logic        resetn;
    logic        ivalid;
    logic        startNewTop;
    logic        iready;
    logic [63:0] botLower;
    logic [63:0] botUpper;
    logic        oready;
    logic        ovalid;
    result_t     resultOut;

    stimEntry_t stimTable[$];
    expected_t  expQueue[$];
    expected_t  expHead;
    expected_t  newExp;
    bitset_t    genTop;    // Latest top in table order
    bitset_t    modelTop;  // Latest top in acceptance order
    int         cycleCount = 0;
    int         cycleLimit = 0;
    int         topsSeen = 0;
    int         topsOutstanding = 0;
    bit         sawStall = 1'b0;

    permutationAccelerator DUT (
        .clk        (clk),
        .resetn     (resetn),
        .ivalid     (ivalid),
        .startNewTop(startNewTop),
        .iready     (iready),
        .botLower   (botLower),
        .botUpper   (botUpper),
        .oready     (oready),
        .ovalid     (ovalid),
        .resultOut  (resultOut)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic checkValue(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "Check failed");
        end
    endtask

    // Count and sum over the four rotations from the truth-table rule
    function automatic result_t expectedBotWord(input bitset_t topSet, input bitset_t botSet);
        result_t word;
        bit      subset;
        int      missing;
        word = '0;
        for (int k = 0; k < 4; k++) begin
            subset  = 1'b1;
            missing = 0;
            for (int i = 0; i < 128; i++) begin
                // Rotating left by 32k puts bot bit (i - 32k) mod 128 at position i
                if (botSet[(i + 128 - 32 * k) % 128]) begin
                    if (!topSet[i]) subset = 1'b0;
                end else if (topSet[i]) begin
                    missing++;
                end
            end
            if (subset) begin
                word.count = word.count + 13'd1;
                word.sum   = word.sum + 48'(missing);
            end
        end
        return word;
    endfunction

    task automatic addEntry(input bit valid, input bit newTop, input bitset_t word,
                            input bit [15:0] pattern);
        stimEntry_t e;
        e.valid        = valid;
        e.newTop       = newTop;
        e.word         = word;
        e.readyPattern = pattern;
        if (valid && newTop) genTop = word;
        stimTable.push_back(e);
    endtask

    task automatic buildTable();
        bitset_t word;
        bit      newTop;
        addEntry(1, 1, '1, 16'hFFFF);  // Dense top where every rotation fits
        addEntry(1, 0, '0, 16'hFFFF);
        addEntry(1, 0, {4{32'h8000_0001}}, 16'hFFFF);
        addEntry(1, 0, '1, 16'hFFFF);
        addEntry(0, 0, '0, 16'hFFFF);
        // Half-lane top where only some rotations fit
        addEntry(1, 1, {32'hFFFF_FFFF, 32'h0, 32'hFFFF_FFFF, 32'h0}, 16'hFFFF);
        addEntry(1, 0, {96'h0, 32'h1234_5678}, 16'hFFFF);
        addEntry(1, 0, {64'h0, 64'h00F0_0000_0000_0F00}, 16'hAAAA);
        addEntry(1, 0, {32'h0, 32'hC0DE_0000, 64'h0}, 16'h0000);  // Still in flight at the swap
        addEntry(1, 0, 128'h3, 16'h0000);
        addEntry(1, 1, {4{32'h0F0F_00FF}}, 16'h0000);
        addEntry(1, 0, {4{32'h0000_00F0}}, 16'h8001);
        addEntry(1, 0, {96'h0, 32'h0F00_0001}, 16'h8001);
        // Long iready low stretches back the buffers up
        for (int n = 0; n < 12; n++) begin
            addEntry(1, 0, {4{32'h0000_0F0F}} >> n, 16'h0000);
        end
        addEntry(0, 0, '0, 16'hFFFF);
        for (int n = 0; n < 40; n++) begin
            word   = {$urandom, $urandom, $urandom, $urandom};
            newTop = ($urandom % 8) == 0;
            if (newTop) word = word | {$urandom, $urandom, $urandom, $urandom};
            else if ($urandom % 2) word = word & genTop;  // Subset of the current top
            addEntry(1, newTop, word, 16'($urandom));
        end
    endtask

    // Holds one entry on the inputs until it is taken, or 16 cycles for an idle entry
    task automatic applyEntry(input stimEntry_t e);
        int c;
        bit done;
        c    = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            ivalid      <= e.valid;
            startNewTop <= e.newTop;
            {botUpper, botLower} <= e.word;
            iready      <= (c >= 16) ? 1'b1 : e.readyPattern[c];
            @(negedge clk);
            c++;
            done = e.valid ? oready : (c >= 16);
        end
    endtask

    // Handshakes are sampled mid-cycle and complete on the next rising edge
    always @(negedge clk) begin
        if (ivalid && oready) begin
            newExp.isTop = startNewTop;
            newExp.word  = '0;
            if (startNewTop) begin
                modelTop = {botUpper, botLower};
                topsOutstanding++;
            end else begin
                newExp.word = expectedBotWord(modelTop, {botUpper, botLower});
            end
            expQueue.push_back(newExp);
        end
        // With no top in flight only full buffers can hold oready low
        if (ivalid && !oready && !iready && topsOutstanding == 0) sawStall = 1'b1;
        if (ovalid && iready) begin
            checkValue(64'(expQueue.size() != 0), 64'd1, "output word with nothing expected");
            expHead = expQueue.pop_front();
            if (expHead.isTop) begin
                topsOutstanding--;
                checkValue(64'(resultOut[63:61]), 64'd0, "profiling word top bits");
                checkValue(64'(resultOut[60:31] <= 3 * resultOut[30:0]), 64'd1,
                           "profiling activity above 3 per cycle");
                if (topsSeen > 0) begin
                    checkValue(64'(resultOut[30:0] != 0), 64'd1, "profiling cycle field");
                end
                topsSeen++;
            end else begin
                checkValue(resultOut, expHead.word, "bot result word");
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("SIMULATION FAILED");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        void'($urandom(32'h4ff3a391));
        resetn      = 1'b0;
        ivalid      = 1'b0;
        startNewTop = 1'b0;
        iready      = 1'b0;
        botLower    = '0;
        botUpper    = '0;
        buildTable();
        cycleLimit = 40 * stimTable.size() + 200;
        repeat (8) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        while (!oready) begin
            checkValue(64'(ovalid), 64'd0, "ovalid while internal reset runs");
            @(negedge clk);
        end
        checkValue(64'(ovalid), 64'd0, "ovalid before any input");
        foreach (stimTable[n]) applyEntry(stimTable[n]);
        @(posedge clk);
        ivalid      <= 1'b0;
        startNewTop <= 1'b0;
        iready      <= 1'b1;
        while (expQueue.size() != 0) @(negedge clk);
        repeat (20) @(negedge clk);  // Any extra word now shows up as unexpected
        checkValue(64'(sawStall), 64'd1, "oready never fell while iready was low");
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: topManager.sv
`timescale 1ns/1ns
`include "permPipe_params.svh"

module topManager (
    input  logic             clk,
    input  logic             rst,
    input  logic             topValid,
    input  logic             botWrite,
    input  logic             botDrained,
    input  permPkg::bitset_t topIn,
    output permPkg::bitset_t topOut,
    output logic             stallInput
);

    import permPkg::*;

    // Bots in flight are bounded by the origin queue depth
    logic [`PERM_ORIGIN_DEPTH_LOG2:0] botsInFlight;
    logic                             topPending;
    bitset_t                          pendingTop;

    always_ff @(posedge clk) begin
        if (rst) begin
            botsInFlight <= '0;
            topPending   <= 1'b0;
        end else begin
            botsInFlight <= botsInFlight + (`PERM_ORIGIN_DEPTH_LOG2 + 1)'(botWrite)
                                         - (`PERM_ORIGIN_DEPTH_LOG2 + 1)'(botDrained);
            if (topValid) begin
                topPending <= 1'b1;
            end else if (topPending && botsInFlight == '0) begin
                topPending <= 1'b0;  // Swap done
            end
        end
    end

    always_ff @(posedge clk) begin
        if (topValid) pendingTop <= topIn;                         // Park the new top
        if (topPending && !topValid && botsInFlight == '0) begin
            topOut <= pendingTop;  // Old bots all gone
        end
    end

    assign stallInput = topPending;

endmodule
